// ==== source/adc_pkg.sv ====
package adc_pkg;

    typedef logic [15:0] adc_sample_t; // one conversion result
    typedef logic [2:0]  channel_t;
    typedef logic [4:0]  slot_t;       // position in a 32-cycle read slot
    typedef logic [15:0] busy_count_t;

    localparam int num_channels = 8;

    // data is sampled here, in the first cycle after rd_n returns high
    localparam slot_t capture_slot = 5'd16;

    // outputs of the ADC as seen by the FPGA
    typedef struct packed {
        logic        busy;
        logic        firstdata; // high while channel 0 is on the bus
        adc_sample_t data;
    } adc_in_t;

    // control lines into the ADC, all active low
    typedef struct packed {
        logic convst_n;
        logic cs_n;
        logic rd_n;
    } adc_ctrl_t;

endpackage

// ==== source/video_pkg.sv ====
package video_pkg;

    typedef logic [9:0]   beam_t;
    typedef logic [15:0]  rgb565_t;
    typedef logic [127:0] display_word_t; // count, then channels 6..0

    typedef struct packed {
        beam_t beam_x;
        beam_t beam_y;
        logic  hsync_n;
        logic  vsync_n;
        logic  blank;
    } video_timing_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic       hsync_n;
        logic       vsync_n;
        logic       blank;
    } video_pixel_t;

    localparam int cell_width  = 12; // 6 font columns doubled
    localparam int cell_height = 16; // 8 font rows doubled
    localparam int num_digits  = 32;

    // 6x8 hex glyphs, bit 5 is the leftmost pixel
    localparam logic [5:0] hex_font [0:15][0:7] = '{
        '{6'h1c, 6'h22, 6'h26, 6'h2a, 6'h32, 6'h22, 6'h1c, 6'h00}, // 0
        '{6'h08, 6'h18, 6'h08, 6'h08, 6'h08, 6'h08, 6'h1c, 6'h00}, // 1
        '{6'h1c, 6'h22, 6'h02, 6'h04, 6'h08, 6'h10, 6'h3e, 6'h00}, // 2
        '{6'h3e, 6'h04, 6'h08, 6'h04, 6'h02, 6'h22, 6'h1c, 6'h00}, // 3
        '{6'h04, 6'h0c, 6'h14, 6'h24, 6'h3e, 6'h04, 6'h04, 6'h00}, // 4
        '{6'h3e, 6'h20, 6'h3c, 6'h02, 6'h02, 6'h22, 6'h1c, 6'h00}, // 5
        '{6'h0c, 6'h10, 6'h20, 6'h3c, 6'h22, 6'h22, 6'h1c, 6'h00}, // 6
        '{6'h3e, 6'h02, 6'h04, 6'h08, 6'h10, 6'h10, 6'h10, 6'h00}, // 7
        '{6'h1c, 6'h22, 6'h22, 6'h1c, 6'h22, 6'h22, 6'h1c, 6'h00}, // 8
        '{6'h1c, 6'h22, 6'h22, 6'h1e, 6'h02, 6'h04, 6'h18, 6'h00}, // 9
        '{6'h1c, 6'h22, 6'h22, 6'h22, 6'h3e, 6'h22, 6'h22, 6'h00}, // a
        '{6'h3c, 6'h22, 6'h22, 6'h3c, 6'h22, 6'h22, 6'h3c, 6'h00}, // b
        '{6'h1c, 6'h22, 6'h20, 6'h20, 6'h20, 6'h22, 6'h1c, 6'h00}, // c
        '{6'h38, 6'h24, 6'h22, 6'h22, 6'h22, 6'h24, 6'h38, 6'h00}, // d
        '{6'h3e, 6'h20, 6'h20, 6'h3c, 6'h20, 6'h20, 6'h3e, 6'h00}, // e
        '{6'h3e, 6'h20, 6'h20, 6'h3c, 6'h20, 6'h20, 6'h20, 6'h00}  // f
    };

    // one foreground colour per 16-bit word, count first
    localparam rgb565_t digit_palette [0:7] = '{
        16'hffe0, 16'hf800, 16'h07e0, 16'h001f,
        16'hf81f, 16'h07ff, 16'hfd20, 16'hffff
    };

endpackage

// ==== source/adc_readout.sv ====
module adc_readout
    import adc_pkg::*;
    import video_pkg::*;
#(
    parameter int conv_period_bits = 9
)
(
    input  logic          clk_pixel,
    input  logic          arst_n,
    input  adc_in_t       adc_in,
    output adc_ctrl_t     adc_ctrl,
    output display_word_t display
);

    logic [conv_period_bits-1:0] conv_timer; // free running
    logic [2:0]                  busy_sync;  // two sync stages plus edge history
    logic                        busy_s;
    logic                        busy_fall;
    slot_t                       slot;
    channel_t                    chan_idx;   // channel the next read belongs to
    adc_sample_t [num_channels-1:0] samples;
    busy_count_t                 conv_total;

    // conversion start timer
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
            conv_timer <= '0;
        else
            conv_timer <= conv_timer + 1'b1;
    end

    // low for one eighth of the period, counts 384..447 at 9 bits
    assign adc_ctrl.convst_n = (conv_timer[conv_period_bits-1 -: 3] != 3'd6);

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
            busy_sync <= '0;
        else
            busy_sync <= {busy_sync[1:0], adc_in.busy};
    end

    assign busy_s    = busy_sync[1];
    assign busy_fall = busy_sync[2] & ~busy_sync[1]; // conversion finished

    // read slot sequencer, parked at 31 while the ADC converts
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
            slot <= '1;
        else if (busy_s)
            slot <= '1;
        else
            slot <= slot + 1'b1;
    end

    // 16 cycles low then 16 high per read
    assign adc_ctrl.rd_n = slot[4];
    assign adc_ctrl.cs_n = slot[4];

    // sample bank, firstdata realigns the channel index
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            samples  <= '0;
            chan_idx <= '0;
        end
        else if (slot == capture_slot)
        begin
            if (adc_in.firstdata)
            begin
                samples[0] <= adc_in.data;
                chan_idx   <= channel_t'(1);
            end
            else
            begin
                samples[chan_idx] <= adc_in.data;
                chan_idx          <= chan_idx + 1'b1; // wraps after channel 7
            end
        end
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
            conv_total <= '0;
        else if (busy_fall)
            conv_total <= conv_total + 1'b1;
    end

    // channel 7 is kept but does not fit in the 32 digits
    assign display = {conv_total, samples[6:0]};

endmodule

// ==== source/hex_overlay.sv ====
module hex_overlay
    import video_pkg::*;
(
    input  logic          clk_pixel,
    input  logic          arst_n,
    input  video_timing_t beam,
    input  display_word_t display,
    output video_pixel_t  pixel
);

    logic [5:0] digit;      // 0..39 across the line
    logic [3:0] x_in_cell;  // 0..11
    logic [3:0] y_in_cell;  // 0..15
    logic [2:0] glyph_col;
    logic [2:0] glyph_row;
    logic [4:0] nib_sel;    // nibble position counted from the lsb
    logic [3:0] nibble;
    logic [5:0] glyph_bits;
    logic       font_on;
    logic       in_row;
    rgb565_t    colour;

    // cell position
    assign digit     = 6'(beam.beam_x / cell_width);
    assign x_in_cell = 4'(beam.beam_x % cell_width);
    assign y_in_cell = 4'(beam.beam_y % cell_height);

    // scale by two
    assign glyph_col = x_in_cell[3:1];
    assign glyph_row = y_in_cell[3:1];

    assign in_row = (digit < 6'(num_digits));

    // digit 0 shows the most significant nibble
    assign nib_sel = 5'(num_digits - 1) - digit[4:0];
    assign nibble  = display[{nib_sel, 2'b00} +: 4];

    assign glyph_bits = hex_font[nibble][glyph_row];
    assign font_on    = glyph_bits[3'd5 - glyph_col];

    always_comb
    begin
        if (beam.blank || !in_row || !font_on)
            colour = '0;
        else
            colour = digit_palette[digit[4:2]]; // four digits per word
    end

    // align colour with sync and blank, one cycle behind the beam
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pixel.red     <= '0;
            pixel.green   <= '0;
            pixel.blue    <= '0;
            pixel.hsync_n <= 1'b1;
            pixel.vsync_n <= 1'b1;
            pixel.blank   <= 1'b1;
        end
        else
        begin
            // 565 to 888, low bits filled with the field lsb
            pixel.red     <= {colour[15:11], {3{colour[11]}}};
            pixel.green   <= {colour[10:5], {2{colour[5]}}};
            pixel.blue    <= {colour[4:0], {3{colour[0]}}};
            pixel.hsync_n <= beam.hsync_n;
            pixel.vsync_n <= beam.vsync_n;
            pixel.blank   <= beam.blank;
        end
    end

endmodule

// ==== source/video_timing.sv ====
module video_timing
    import video_pkg::*;
#(
    parameter int h_active = 480,
    parameter int h_front  = 24,
    parameter int h_sync   = 48,
    parameter int h_back   = 72,
    parameter int v_active = 272,
    parameter int v_front  = 1,
    parameter int v_sync   = 3,
    parameter int v_back   = 19
)
(
    input  logic          clk_pixel,
    input  logic          arst_n,
    output video_timing_t beam
);

    localparam int h_total = h_active + h_front + h_sync + h_back; // 624
    localparam int v_total = v_active + v_front + v_sync + v_back; // 295

    localparam beam_t h_last       = beam_t'(h_total - 1);
    localparam beam_t v_last       = beam_t'(v_total - 1);
    localparam beam_t h_sync_start = beam_t'(h_active + h_front);
    localparam beam_t h_sync_end   = beam_t'(h_active + h_front + h_sync);
    localparam beam_t v_sync_start = beam_t'(v_active + v_front);
    localparam beam_t v_sync_end   = beam_t'(v_active + v_front + v_sync);

    beam_t h_count;
    beam_t v_count;

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else if (h_count == h_last)
        begin
            h_count <= '0;
            if (v_count == v_last)
                v_count <= '0;
            else
                v_count <= v_count + 1'b1;
        end
        else
        begin
            h_count <= h_count + 1'b1;
        end
    end

    assign beam.beam_x = h_count;
    assign beam.beam_y = v_count;

    // sync pulses low inside their window
    assign beam.hsync_n = !(h_count >= h_sync_start && h_count < h_sync_end);
    assign beam.vsync_n = !(v_count >= v_sync_start && v_count < v_sync_end);

    assign beam.blank = (h_count >= beam_t'(h_active)) || (v_count >= beam_t'(v_active));

endmodule

// ==== source/adc_hex_display.sv ====
module adc_hex_display
    import adc_pkg::*;
    import video_pkg::*;
#(
    parameter int conv_period_bits = 9,   // 512 clocks per conversion
    parameter int h_active         = 480,
    parameter int h_front          = 24,
    parameter int h_sync           = 48,
    parameter int h_back           = 72,
    parameter int v_active         = 272,
    parameter int v_front          = 1,
    parameter int v_sync           = 3,
    parameter int v_back           = 19
)
(
    input  logic         clk_pixel,
    input  logic         arst_n,
    input  adc_in_t      adc_in,
    output adc_ctrl_t    adc_ctrl,
    output video_pixel_t pixel
);

    display_word_t display;
    video_timing_t beam;

    adc_readout #(
        .conv_period_bits (conv_period_bits)
    ) u_adc_readout (
        .clk_pixel (clk_pixel),
        .arst_n    (arst_n),
        .adc_in    (adc_in),
        .adc_ctrl  (adc_ctrl),
        .display   (display)
    );

    video_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) u_video_timing (
        .clk_pixel (clk_pixel),
        .arst_n    (arst_n),
        .beam      (beam)
    );

    // pixel lags the beam counters by one clock
    hex_overlay u_hex_overlay (
        .clk_pixel (clk_pixel),
        .arst_n    (arst_n),
        .beam      (beam),
        .display   (display),
        .pixel     (pixel)
    );

endmodule

// ==== testbench/adc_hex_display_asserts.sv ====
module adc_hex_display_asserts
(
    input logic clk_pixel,
    input logic arst_n,
    input logic cs_n,
    input logic rd_n,
    input logic busy_s,
    input logic hsync_n,
    input logic blank
);

    // chip select follows the read strobe
    cs_matches_rd: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        cs_n == rd_n)
        else $error("cs_n differs from rd_n");

    // no read while converting
    no_read_when_busy: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        $past(busy_s) |-> rd_n)
        else $error("rd_n low while busy is high");

    hsync_in_blank: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        !hsync_n |-> blank)
        else $error("hsync_n low outside blank");

endmodule

bind adc_hex_display adc_hex_display_asserts u_asserts (
    .clk_pixel (clk_pixel),
    .arst_n    (arst_n),
    .cs_n      (adc_ctrl.cs_n),
    .rd_n      (adc_ctrl.rd_n),
    .busy_s    (u_adc_readout.busy_s),
    .hsync_n   (beam.hsync_n),
    .blank     (beam.blank)
);

// ==== testbench/tb_adc_hex_display.sv ====
module tb_adc_hex_display
    import adc_pkg::*;
    import video_pkg::*;
;

    localparam int num_rows   = 6;
    localparam int line_len   = 624;
    localparam int frame_len  = 295 * line_len; // 184080 cycles
    localparam longint watchdog_time = (longint'(num_rows) * 512 + 3 * frame_len) * 4;

    // one row per conversion: busy length, then channels 0..7
    localparam int busy_tab [0:num_rows-1] = '{20, 45, 90, 130, 170, 200};
    localparam logic [15:0] chan_tab [0:num_rows-1][0:7] = '{
        '{16'h0123, 16'h4567, 16'h89ab, 16'hcdef, 16'h1111, 16'h2222, 16'h3333, 16'h4444},
        '{16'hffff, 16'h0000, 16'haaaa, 16'h5555, 16'h1234, 16'h5678, 16'h9abc, 16'hdef0},
        '{16'h0f0f, 16'hf0f0, 16'h00ff, 16'hff00, 16'h7e7e, 16'h8181, 16'h3c3c, 16'hc3c3},
        '{16'hbeef, 16'hcafe, 16'hdead, 16'hf00d, 16'hface, 16'hfeed, 16'hbead, 16'hc0de},
        '{16'h1357, 16'h2468, 16'h9bdf, 16'hace0, 16'h0f1e, 16'h2d3c, 16'h4b5a, 16'h6978},
        '{16'ha1b2, 16'hc3d4, 16'he5f6, 16'h0718, 16'h293a, 16'h4b5c, 16'h6d7e, 16'h8f90}
    };

    logic          clk_pixel;
    logic          arst_n;
    adc_in_t       adc_in;
    adc_ctrl_t     adc_ctrl;
    video_pixel_t  pixel;

    int            mismatches;
    int            other_errors;
    int            cur_row;
    int            read_k;
    logic          frozen;
    logic          frame_done;
    display_word_t exp_word;

    adc_hex_display DUT (
        .clk_pixel (clk_pixel),
        .arst_n    (arst_n),
        .adc_in    (adc_in),
        .adc_ctrl  (adc_ctrl),
        .pixel     (pixel)
    );

    always #2 clk_pixel = ~clk_pixel;

    // colour of one active pixel from the cell, font and palette rule
    function automatic logic [23:0] expected_rgb(display_word_t w, int x, int y);
        int         d;
        logic [3:0] nib;
        logic [5:0] row_bits;
        rgb565_t    c;
        d = x / 12;
        if (d >= 32)
            return 24'h0;
        nib      = w[127 - 4 * d -: 4];
        row_bits = hex_font[nib][(y % 16) / 2];
        if (!row_bits[5 - (x % 12) / 2])
            return 24'h0;
        c = digit_palette[d / 4];
        return {c[15:11], {3{c[11]}}, c[10:5], {2{c[5]}}, c[4:0], {3{c[0]}}};
    endfunction

    // ADC conversion model, one table row per convst_n rise
    initial
    begin
        clk_pixel    = 1'b0;
        arst_n       = 1'b0;
        adc_in       = '0;
        mismatches   = 0;
        other_errors = 0;
        cur_row      = 0;
        read_k       = 0;
        frozen       = 1'b0;
        frame_done   = 1'b0;
        exp_word     = '0;
        repeat (10) @(posedge clk_pixel);
        arst_n <= 1'b1;
        for (int r = 0; r < num_rows; r++)
        begin
            @(posedge adc_ctrl.convst_n);
            @(posedge clk_pixel);
            adc_in.busy <= 1'b1;
            repeat (busy_tab[r]) @(posedge clk_pixel);
            adc_in.busy <= 1'b0;
            cur_row = r;
            read_k  = 0;
        end
        @(posedge adc_ctrl.convst_n);
        @(posedge clk_pixel);
        adc_in.busy <= 1'b1; // held from here on, display freezes
        exp_word[127:112] = 16'(num_rows);
        for (int ch = 0; ch < 7; ch++)
            exp_word[ch*16 +: 16] = chan_tab[num_rows-1][ch];
        frozen = 1'b1;
    end

    // data for read k, changed after each rd_n fall
    logic rd_prev;
    int   rd_low;
    int   rd_high;
    int   busy_high_cycles;
    int   busy_low_cycles;
    always @(posedge clk_pixel)
    begin
        if (arst_n)
        begin
            if (rd_prev && !adc_ctrl.rd_n)
            begin
                adc_in.data      <= chan_tab[cur_row][read_k % 8];
                adc_in.firstdata <= (read_k == 0);
                read_k           = read_k + 1;
                assert (busy_high_cycles <= 2)
                else
                begin
                    $display("rd_n fell at time %0t while the ADC was converting", $time);
                    other_errors++;
                end
                assert (rd_high >= 16)
                else
                begin
                    $display("Mismatch at %0t: rd_n high for %0d cycles", $time, rd_high);
                    mismatches++;
                end
            end
            if (!rd_prev && adc_ctrl.rd_n && busy_low_cycles > 3)
            begin
                assert (rd_low == 16)
                else
                begin
                    $display("Mismatch at %0t: rd_n low for %0d cycles", $time, rd_low);
                    mismatches++;
                end
            end
            rd_low  = adc_ctrl.rd_n ? 0 : rd_low + 1;
            rd_high = adc_ctrl.rd_n ? rd_high + 1 : 0;
            busy_high_cycles = adc_in.busy ? busy_high_cycles + 1 : 0;
            busy_low_cycles  = adc_in.busy ? 0 : busy_low_cycles + 1;
        end
        else
        begin
            rd_low           = 0;
            rd_high          = 16;
            busy_high_cycles = 0;
            busy_low_cycles  = 100;
        end
        rd_prev = adc_ctrl.rd_n;
    end

    // cycle numbers of the last falling edges
    int   cyc;
    logic cv_prev;
    logic hs_prev;
    logic vs_prev;
    logic bl_prev;
    int   cv_fall;
    int   hs_fall;
    int   vs_fall;
    int   bl_fall;
    int   px;
    int   py;
    logic armed;

    task automatic check_len(input string what, input int got, input int want);
        assert (got == want)
        else
        begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
            mismatches++;
        end
    endtask

    always @(posedge clk_pixel)
    begin
        if (!arst_n)
        begin
            cyc     = 0;
            cv_fall = -1;
            hs_fall = -1;
            vs_fall = -1;
            bl_fall = -1;
            px      = 0;
            py      = 0;
            armed   = 1'b0;
        end
        else
        begin
            cyc++;
            if (cv_prev && !adc_ctrl.convst_n)
            begin
                if (cv_fall >= 0)
                    check_len("convst_n period", cyc - cv_fall, 512);
                cv_fall = cyc;
            end
            if (!cv_prev && adc_ctrl.convst_n && cv_fall >= 0)
                check_len("convst_n low time", cyc - cv_fall, 64);
            if (hs_prev && !pixel.hsync_n)
            begin
                if (hs_fall >= 0)
                    check_len("hsync_n period", cyc - hs_fall, line_len);
                hs_fall = cyc;
            end
            if (!hs_prev && pixel.hsync_n && hs_fall >= 0)
                check_len("hsync_n low time", cyc - hs_fall, 48);
            if (vs_prev && !pixel.vsync_n)
            begin
                if (vs_fall >= 0)
                    check_len("vsync_n period", cyc - vs_fall, frame_len);
                check_len("active lines per frame", py, 272);
                vs_fall = cyc;
            end
            if (!vs_prev && pixel.vsync_n && vs_fall >= 0)
                check_len("vsync_n low time", cyc - vs_fall, 3 * line_len);
            if (!pixel.vsync_n)
            begin
                py = 0;
                if (frozen)
                    armed = 1'b1;
            end
            if (bl_prev && !pixel.blank)
            begin
                bl_fall = cyc;
                px = 0;
            end
            if (!bl_prev && pixel.blank && bl_fall >= 0)
            begin
                check_len("active pixels per line", cyc - bl_fall, 480);
                py++;
                if (armed && py == 272)
                    frame_done = 1'b1;
            end
            if (pixel.blank)
            begin
                check_len("blanked pixel colour",
                          int'({pixel.red, pixel.green, pixel.blue}), 0);
            end
            else
            begin
                if (armed)
                    check_len($sformatf("pixel colour at %0d,%0d", px, py),
                              int'({pixel.red, pixel.green, pixel.blue}),
                              int'(expected_rgb(exp_word, px, py)));
                px++;
            end
        end
        cv_prev = adc_ctrl.convst_n;
        hs_prev = pixel.hsync_n;
        vs_prev = pixel.vsync_n;
        bl_prev = pixel.blank;
    end

    initial
    begin
        #(watchdog_time);
        $display("Timeout: the checked frame was not drawn in time");
        other_errors++;
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        wait (frame_done);
        @(posedge clk_pixel);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
source/adc_pkg.sv
source/video_pkg.sv
source/adc_readout.sv
source/hex_overlay.sv
source/video_timing.sv
source/adc_hex_display.sv
testbench/adc_hex_display_asserts.sv
testbench/tb_adc_hex_display.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_adc_hex_display
FILELIST  ?= filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
